/* hw/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

    localparam int xlen        = 32;
    localparam int mask_w      = xlen / 8;   // One enable per byte lane
    localparam int word_addr_w = xlen - 2;   // Byte address without the lane bits

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store,
        mem_atomic
    } mem_sel_t;

    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w
    } mem_size_t;

    // Shared by load extension and AMO MIN/MAX
    typedef enum logic {
        op_signed,
        op_unsigned
    } sign_sel_t;

    typedef enum logic [3:0] {
        amo_lr,
        amo_sc,
        amo_swap,
        amo_add,
        amo_xor,
        amo_and,
        amo_or,
        amo_min,
        amo_max
    } amo_sel_t;

    typedef enum logic [3:0] {
        cause_load_access_fault      = 4'd5,
        cause_store_amo_access_fault = 4'd7
    } cause_t;

endpackage

`default_nettype wire

/* hw/mem_stage_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_fsm
    import mem_stage_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      valid,
    input  wire                      is_new,
    input  wire mem_sel_t            mem_sel,
    input  wire mem_size_t           mem_size,
    input  wire amo_sel_t            amo_sel,
    input  wire [xlen-1:0]           addr,
    input  wire                      req_ready,
    input  wire                      resp_valid,
    input  wire [xlen-1:0]           resp_rdata,
    input  wire                      resp_error,
    output logic                     req_valid,
    output logic                     req_wen,
    output logic [word_addr_w-1:0]   req_addr,
    output logic [xlen-1:0]          saved_rdata,
    output logic                     sc_success,
    output logic                     amo_write_phase,
    output logic                     is_stall,
    output logic                     trap_valid,
    output cause_t                   trap_cause
);

    typedef enum logic [1:0] {
        idle,
        wait_ready,
        wait_rdata,
        wait_wresp
    } state_t;

    state_t          state;
    logic            err_flag;     // Last finished operation hit a fault
    logic            resv_valid;
    logic [xlen-1:0] resv_addr;
    logic            sc_hit;
    logic            is_sc;
    logic            is_amo_rmw;
    logic            is_load_op;

    assign is_sc      = (mem_sel == mem_atomic) && (amo_sel == amo_sc);
    assign is_amo_rmw = (mem_sel == mem_atomic) && (amo_sel != amo_lr) && (amo_sel != amo_sc);
    assign is_load_op = (mem_sel == mem_load) || ((mem_sel == mem_atomic) && (amo_sel == amo_lr));
    assign sc_hit     = resv_valid && (resv_addr == addr);

    // SC and the AMO second pass are the only atomic writes
    assign req_wen   = (mem_sel == mem_store) || is_sc || amo_write_phase;
    assign req_valid = valid && (state == wait_ready);
    assign req_addr  = addr[xlen-1:2];

    assign is_stall   = valid && ((state == idle && is_new && mem_sel != mem_none) ||
                                  state != idle);
    assign trap_valid = valid && (state == idle) && !is_new && err_flag;
    assign trap_cause = is_load_op ? cause_load_access_fault : cause_store_amo_access_fault;

    // Single reservation, kept across operations
    always_ff @(posedge clk) begin
        if (rst) begin
            resv_valid <= 1'b0;
        end else if (valid && is_new && state == idle && mem_sel == mem_atomic) begin
            if (amo_sel == amo_lr) begin
                resv_valid <= 1'b1;
                resv_addr  <= addr;
            end else if (amo_sel == amo_sc) begin
                resv_valid <= 1'b0;   // Any SC drops it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !valid) begin
            state           <= idle;
            amo_write_phase <= 1'b0;
            err_flag        <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (is_new) begin
                        amo_write_phase <= 1'b0;
                        err_flag        <= 1'b0;
                        if (is_sc) begin
                            sc_success <= sc_hit;
                            if (sc_hit) begin
                                state <= wait_ready;
                            end
                        end else if (mem_sel != mem_none) begin
                            state <= wait_ready;
                        end
                    end
                end
                wait_ready: begin
                    if (req_ready) begin
                        state <= req_wen ? wait_wresp : wait_rdata;
                    end
                end
                wait_rdata: begin
                    if (resp_valid) begin
                        saved_rdata <= resp_rdata >> {addr[1:0], 3'b000};  // Lane to bit 0
                        if (resp_error) begin
                            state    <= idle;
                            err_flag <= 1'b1;
                        end else if (is_amo_rmw) begin
                            state           <= wait_ready;
                            amo_write_phase <= 1'b1;
                        end else begin
                            state <= idle;
                        end
                    end
                end
                wait_wresp: begin
                    if (resp_valid) begin
                        state    <= idle;
                        err_flag <= resp_error;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Failed SC and no-op cycles never reach memory
    a_req_needs_op: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> ((mem_sel != mem_none) && !(is_sc && !sc_success)));

    // Timer must never answer a request this FSM did not issue
    a_no_resp_in_idle: assert property (@(posedge clk) disable iff (rst)
        !(state == idle && resp_valid));

    a_inputs_held: assert property (@(posedge clk) disable iff (rst)
        (valid && state != idle) |-> ($stable(mem_sel) && $stable(mem_size) && $stable(addr)));

endmodule

`default_nettype wire

/* hw/mem_data_format.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_data_format
    import mem_stage_pkg::*;
(
    input  wire mem_sel_t      mem_sel,
    input  wire mem_size_t     mem_size,
    input  wire sign_sel_t     sign_sel,
    input  wire amo_sel_t      amo_sel,
    input  wire [xlen-1:0]     addr,
    input  wire [xlen-1:0]     rs2_data,
    input  wire [xlen-1:0]     saved_rdata,
    input  wire                sc_success,
    input  wire                amo_write_phase,
    output logic [xlen-1:0]    req_wdata,
    output logic [mask_w-1:0]  req_wmask,
    output logic [xlen-1:0]    rdata
);

    logic [1:0]        ofs;
    logic [mask_w-1:0] lane_mask;
    logic [xlen-1:0]   amo_result;
    logic              old_lt;   // Memory word below rs2

    assign ofs = addr[1:0];

    always_comb begin
        if (sign_sel == op_signed) begin
            old_lt = $signed(saved_rdata) < $signed(rs2_data);
        end else begin
            old_lt = saved_rdata < rs2_data;
        end
        case (amo_sel)
            amo_swap: amo_result = rs2_data;
            amo_add:  amo_result = saved_rdata + rs2_data;
            amo_xor:  amo_result = saved_rdata ^ rs2_data;
            amo_and:  amo_result = saved_rdata & rs2_data;
            amo_or:   amo_result = saved_rdata | rs2_data;
            amo_min:  amo_result = old_lt ? saved_rdata : rs2_data;
            amo_max:  amo_result = old_lt ? rs2_data : saved_rdata;
            default:  amo_result = rs2_data;
        endcase
    end

    always_comb begin
        case (mem_size)
            size_b:  lane_mask = 4'b0001;
            size_h:  lane_mask = 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
        if (mem_sel == mem_atomic) begin
            // Atomics are always full aligned words
            req_wdata = amo_write_phase ? amo_result : rs2_data;
            req_wmask = '1;
        end else begin
            req_wdata = rs2_data << {ofs, 3'b000};
            req_wmask = lane_mask << ofs;
        end
    end

    always_comb begin
        if (mem_sel == mem_atomic) begin
            if (amo_sel == amo_sc) begin
                rdata = {{(xlen-1){1'b0}}, !sc_success};   // 0 means stored
            end else begin
                rdata = saved_rdata;   // LR and AMO return the old word
            end
        end else begin
            case (mem_size)
                size_b: begin
                    rdata = {{(xlen-8){sign_sel == op_signed && saved_rdata[7]}},
                             saved_rdata[7:0]};
                end
                size_h: begin
                    rdata = {{(xlen-16){sign_sel == op_signed && saved_rdata[15]}},
                             saved_rdata[15:0]};
                end
                default: rdata = saved_rdata;
            endcase
        end
    end

    always_comb begin
        if (mem_sel != mem_none && mem_size == size_h) begin
            a_half_aligned: assert #0 (!addr[0])
                else $error("halfword access at odd address %h", addr);
        end
    end

endmodule

`default_nettype wire

/* hw/dmem_latency_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module dmem_latency_timer #(
    parameter int resp_latency = 3
) (
    input  wire   clk,
    input  wire   rst,
    input  wire   req_valid,
    output logic  req_ready,
    output logic  resp_valid,
    output logic  req_accept
);

    localparam int cnt_w = $clog2(resp_latency + 1);

    logic             busy;
    logic [cnt_w-1:0] count;   // Cycles left before the response

    assign req_ready  = !busy;
    assign req_accept = req_valid && req_ready;
    assign resp_valid = busy && (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (req_accept) begin
            busy  <= 1'b1;
            count <= cnt_w'(resp_latency - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;   // Response goes out this cycle
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Every response traces back to one acceptance
    a_resp_after_accept: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $past(req_accept, resp_latency));

endmodule

`default_nettype wire

/* hw/dmem_array.sv */
`timescale 1ns/1ns
`default_nettype none

module dmem_array
    import mem_stage_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req_accept,
    input  wire                     req_wen,
    input  wire [word_addr_w-1:0]   req_addr,
    input  wire [xlen-1:0]          req_wdata,
    input  wire [mask_w-1:0]        req_wmask,
    output logic [xlen-1:0]         resp_rdata,
    output logic                    resp_error
);

    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
    localparam logic [word_addr_w-1:0] depth = word_addr_w'(mem_words);

    logic [xlen-1:0]  mem [mem_words];
    logic             in_range;
    logic [idx_w-1:0] idx;

    assign in_range = req_addr < depth;
    assign idx      = req_addr[idx_w-1:0];

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // Old word is returned, so an AMO read sees memory before its write
    always_ff @(posedge clk) begin
        if (req_accept && in_range) begin
            resp_rdata <= mem[idx];
            if (req_wen) begin
                for (int b = 0; b < mask_w; b++) begin
                    if (req_wmask[b]) begin
                        mem[idx][8*b +: 8] <= req_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_error <= 1'b0;
        end else if (req_accept) begin
            resp_error <= !in_range;   // Held until next request
        end
    end

endmodule

`default_nettype wire

/* hw/mem_stage_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top
    import mem_stage_pkg::*;
#(
    parameter int mem_words    = 256,
    parameter int resp_latency = 3
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                valid,
    input  wire                is_new,
    input  wire mem_sel_t      mem_sel,
    input  wire mem_size_t     mem_size,
    input  wire sign_sel_t     sign_sel,
    input  wire amo_sel_t      amo_sel,
    input  wire [xlen-1:0]     addr,
    input  wire [xlen-1:0]     rs2_data,
    output wire                is_stall,
    output wire [xlen-1:0]     rdata,
    output wire                trap_valid,
    output wire cause_t        trap_cause
);

    wire                   req_valid;
    wire                   req_wen;
    wire [word_addr_w-1:0] req_addr;
    wire [xlen-1:0]        req_wdata;
    wire [mask_w-1:0]      req_wmask;
    wire                   req_ready;
    wire                   req_accept;
    wire                   resp_valid;
    wire [xlen-1:0]        resp_rdata;
    wire                   resp_error;
    wire [xlen-1:0]        saved_rdata;
    wire                   sc_success;
    wire                   amo_write_phase;

    mem_stage_fsm i_fsm (
        .clk             (clk),
        .rst             (rst),
        .valid           (valid),
        .is_new          (is_new),
        .mem_sel         (mem_sel),
        .mem_size        (mem_size),
        .amo_sel         (amo_sel),
        .addr            (addr),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .resp_rdata      (resp_rdata),
        .resp_error      (resp_error),
        .req_valid       (req_valid),
        .req_wen         (req_wen),
        .req_addr        (req_addr),
        .saved_rdata     (saved_rdata),
        .sc_success      (sc_success),
        .amo_write_phase (amo_write_phase),
        .is_stall        (is_stall),
        .trap_valid      (trap_valid),
        .trap_cause      (trap_cause)
    );

    mem_data_format i_format (
        .mem_sel         (mem_sel),
        .mem_size        (mem_size),
        .sign_sel        (sign_sel),
        .amo_sel         (amo_sel),
        .addr            (addr),
        .rs2_data        (rs2_data),
        .saved_rdata     (saved_rdata),
        .sc_success      (sc_success),
        .amo_write_phase (amo_write_phase),
        .req_wdata       (req_wdata),
        .req_wmask       (req_wmask),
        .rdata           (rdata)
    );

    // Fixed-latency memory model
    dmem_latency_timer #(
        .resp_latency (resp_latency)
    ) i_timer (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .req_accept (req_accept)
    );

    dmem_array #(
        .mem_words (mem_words)
    ) i_array (
        .clk        (clk),
        .rst        (rst),
        .req_accept (req_accept),
        .req_wen    (req_wen),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .resp_rdata (resp_rdata),
        .resp_error (resp_error)
    );

endmodule

`default_nettype wire

/* verif/mem_stage_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_checker
    import mem_stage_pkg::*;
#(
    parameter int mem_words    = 256,
    parameter int resp_latency = 3
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                valid,
    input  wire                is_new,
    input  wire mem_sel_t      mem_sel,
    input  wire mem_size_t     mem_size,
    input  wire sign_sel_t     sign_sel,
    input  wire amo_sel_t      amo_sel,
    input  wire [xlen-1:0]     addr,
    input  wire [xlen-1:0]     rs2_data,
    input  wire                is_stall,
    input  wire [xlen-1:0]     rdata,
    input  wire                trap_valid,
    input  wire cause_t        trap_cause,
    output int                 checks,
    output int                 errors
);

    logic [31:0] shadow [mem_words];
    logic        resv_ok;
    logic [31:0] resv_a;
    logic        pending;   // An operation waits for its result cycle
    int          stall_len;
    mem_sel_t    op_sel;
    mem_size_t   op_size;
    sign_sel_t   op_sign;
    amo_sel_t    op_amo;
    logic [31:0] op_addr;
    logic [31:0] op_data;

    initial begin
        checks  = 0;
        errors  = 0;
        resv_ok = 1'b0;
        resv_a  = '0;
        pending = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = '0;
        end
    end

    // Expected outputs and memory update of one operation
    function automatic void expected_result(
        input  mem_sel_t    sel,
        input  mem_size_t   size,
        input  sign_sel_t   sgn,
        input  amo_sel_t    amo,
        input  logic [31:0] a,
        input  logic [31:0] d,
        input  logic [31:0] old_word,
        input  logic        in_range,
        input  logic        resv_hit,
        output logic [31:0] exp_rdata,
        output logic        exp_trap,
        output logic [3:0]  exp_cause,
        output logic [31:0] new_word,
        output logic        do_write
    );
        logic [31:0] lane;
        logic        access;
        logic        is_load;
        int          nbytes;
        int          k;
        lane      = old_word >> (8 * a[1:0]);
        exp_rdata = '0;
        exp_trap  = 1'b0;
        exp_cause = '0;
        new_word  = old_word;
        do_write  = 1'b0;
        is_load   = (sel == mem_load) || (sel == mem_atomic && amo == amo_lr);
        access    = (sel == mem_load) || (sel == mem_store) ||
                    (sel == mem_atomic && (amo != amo_sc || resv_hit));
        nbytes    = (size == size_b) ? 1 : (size == size_h) ? 2 : 4;
        if (access && !in_range) begin
            exp_trap  = 1'b1;
            exp_cause = is_load ? 4'd5 : 4'd7;
        end else if (sel == mem_load) begin
            if (nbytes == 1) begin
                exp_rdata = {{24{sgn == op_signed && lane[7]}}, lane[7:0]};
            end else if (nbytes == 2) begin
                exp_rdata = {{16{sgn == op_signed && lane[15]}}, lane[15:0]};
            end else begin
                exp_rdata = old_word;
            end
        end else if (sel == mem_store) begin
            for (k = 0; k < nbytes; k++) begin
                new_word[8*(a[1:0]+k) +: 8] = d[8*k +: 8];
            end
            do_write = 1'b1;
        end else if (sel == mem_atomic) begin
            exp_rdata = old_word;   // LR and AMO give the old word
            do_write  = (amo != amo_lr);
            case (amo)
                amo_sc: begin
                    exp_rdata = resv_hit ? 32'd0 : 32'd1;
                    new_word  = d;
                    do_write  = resv_hit;
                end
                amo_add: new_word = old_word + d;
                amo_xor: new_word = old_word ^ d;
                amo_and: new_word = old_word & d;
                amo_or:  new_word = old_word | d;
                amo_min: begin
                    if (sgn == op_signed) begin
                        new_word = ($signed(d) < $signed(old_word)) ? d : old_word;
                    end else begin
                        new_word = (d < old_word) ? d : old_word;
                    end
                end
                amo_max: begin
                    if (sgn == op_signed) begin
                        new_word = ($signed(d) > $signed(old_word)) ? d : old_word;
                    end else begin
                        new_word = (d > old_word) ? d : old_word;
                    end
                end
                default: new_word = d;   // SWAP, LR unused
            endcase
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h (addr %h)", name, exp_v, act_v, op_addr);
        end
    endtask

    task automatic finish_op();
        logic [31:0] old_word;
        logic [31:0] exp_rdata;
        logic [31:0] new_word;
        logic [3:0]  exp_cause;
        logic        exp_trap;
        logic        do_write;
        logic        in_range;
        int          idx;
        in_range = op_addr[31:2] < mem_words;
        idx      = in_range ? int'(op_addr[31:2]) : 0;
        old_word = in_range ? shadow[idx] : '0;
        expected_result(op_sel, op_size, op_sign, op_amo, op_addr, op_data, old_word,
                        in_range, resv_ok && resv_a == op_addr,
                        exp_rdata, exp_trap, exp_cause, new_word, do_write);
        check_value("trap_valid", exp_trap, trap_valid);
        if (op_sel == mem_none) begin
            check_value("is_stall cycles", 0, stall_len);
        end else if (exp_trap) begin
            check_value("trap_cause", exp_cause, trap_cause);
        end else if (op_sel != mem_store) begin
            check_value("rdata", exp_rdata, rdata);
        end
        if (op_sel == mem_load) begin
            check_value("is_stall cycles", resp_latency + 2, stall_len);
        end
        if (do_write && in_range && !exp_trap) begin
            shadow[idx] = new_word;
        end
        if (op_sel == mem_atomic && op_amo == amo_lr) begin
            resv_ok = 1'b1;
            resv_a  = op_addr;
        end else if (op_sel == mem_atomic && op_amo == amo_sc) begin
            resv_ok = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pending = 1'b0;
        end else if (valid && is_new) begin
            if (pending) begin
                errors++;
                $display("Operation at address %h ended without a result cycle", op_addr);
            end
            op_sel    = mem_sel;
            op_size   = mem_size;
            op_sign   = sign_sel;
            op_amo    = amo_sel;
            op_addr   = addr;
            op_data   = rs2_data;
            pending   = 1'b1;
            stall_len = is_stall ? 1 : 0;
        end else if (pending && valid) begin
            if (is_stall) begin
                stall_len++;
            end else begin
                finish_op();
                pending = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage
    import mem_stage_pkg::*;
();

    localparam int mem_words     = 256;
    localparam int resp_latency  = 3;
    localparam int num_ops       = 32 + 21 + 27 + 11 + 6 + 5;
    localparam int timeout_limit = num_ops * 2 * (resp_latency + 3) + 10 + 100;

    logic        clk;
    logic        rst;
    logic        valid;
    logic        is_new;
    mem_sel_t    mem_sel;
    mem_size_t   mem_size;
    sign_sel_t   sign_sel;
    amo_sel_t    amo_sel;
    logic [31:0] addr;
    logic [31:0] rs2_data;
    wire         is_stall;
    wire [31:0]  rdata;
    wire         trap_valid;
    cause_t      trap_cause;
    int          checks;
    int          errors;
    int          cycles;
    int          seed;
    int          test_num;
    int          checks_at_start;
    int          errors_at_start;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;

    mem_stage_top #(
        .mem_words    (mem_words),
        .resp_latency (resp_latency)
    ) i_dut (
        .clk (clk), .rst (rst), .valid (valid), .is_new (is_new),
        .mem_sel (mem_sel), .mem_size (mem_size), .sign_sel (sign_sel),
        .amo_sel (amo_sel), .addr (addr), .rs2_data (rs2_data),
        .is_stall (is_stall), .rdata (rdata),
        .trap_valid (trap_valid), .trap_cause (trap_cause)
    );

    mem_stage_checker #(
        .mem_words    (mem_words),
        .resp_latency (resp_latency)
    ) i_checker (
        .clk (clk), .rst (rst), .valid (valid), .is_new (is_new),
        .mem_sel (mem_sel), .mem_size (mem_size), .sign_sel (sign_sel),
        .amo_sel (amo_sel), .addr (addr), .rs2_data (rs2_data),
        .is_stall (is_stall), .rdata (rdata), .trap_valid (trap_valid),
        .trap_cause (trap_cause), .checks (checks), .errors (errors)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Watchdog on the cycle counter
    initial begin
        wait (cycles > timeout_limit);
        $display("Run stopped after %0d cycles, an operation never finished", cycles);
        $display("Verification failed");
        $finish;
    end

    // One operation: is_new pulse, hold until stall drops, one idle cycle
    task automatic run_op(input mem_sel_t sel, input mem_size_t size, input sign_sel_t sgn,
                          input amo_sel_t amo, input logic [31:0] op_a,
                          input logic [31:0] op_d);
        @(posedge clk);
        valid    <= 1'b1;
        is_new   <= 1'b1;
        mem_sel  <= sel;
        mem_size <= size;
        sign_sel <= sgn;
        amo_sel  <= amo;
        addr     <= op_a;
        rs2_data <= op_d;
        @(posedge clk);
        is_new <= 1'b0;
        do begin
            @(posedge clk);
        end while (is_stall);
        valid <= 1'b0;
    endtask

    task automatic store_data(input mem_size_t size, input logic [31:0] op_a,
                              input logic [31:0] op_d);
        run_op(mem_store, size, op_unsigned, amo_lr, op_a, op_d);
    endtask

    task automatic load_data(input mem_size_t size, input sign_sel_t sgn,
                             input logic [31:0] op_a);
        run_op(mem_load, size, sgn, amo_lr, op_a, '0);
    endtask

    task automatic begin_test();
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        test_num++;
        $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    // AMO order: SWAP ADD XOR AND OR MIN MIN MAX MAX
    function automatic amo_sel_t amo_at(input int i);
        case (i)
            0: return amo_swap;
            1: return amo_add;
            2: return amo_xor;
            3: return amo_and;
            4: return amo_or;
            5, 6: return amo_min;
            default: return amo_max;
        endcase
    endfunction

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        valid    = 1'b0;
        is_new   = 1'b0;
        mem_sel  = mem_none;
        mem_size = size_w;
        sign_sel = op_signed;
        amo_sel  = amo_lr;
        addr     = '0;
        rs2_data = '0;
        cycles   = 0;
        test_num = 0;
        seed     = 7491;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            a = (r % mem_words) * 4;
            store_data(size_w, a, $random(seed));
            load_data(size_w, op_unsigned, a);
        end
        end_test("word store and load");

        begin_test();
        store_data(size_w, 32'h40, $random(seed));
        for (int o = 0; o < 4; o++) begin
            d    = $random(seed);
            d[7] = o[0];   // Both sign cases
            store_data(size_b, 32'h40 + o, d);
            load_data(size_b, op_signed, 32'h40 + o);
            load_data(size_b, op_unsigned, 32'h40 + o);
        end
        load_data(size_w, op_unsigned, 32'h40);
        for (int o = 0; o < 4; o += 2) begin
            d     = $random(seed);
            d[15] = !o[1];
            store_data(size_h, 32'h40 + o, d);
            load_data(size_h, op_signed, 32'h40 + o);
            load_data(size_h, op_unsigned, 32'h40 + o);
        end
        load_data(size_w, op_unsigned, 32'h40);
        end_test("byte and halfword lanes");

        begin_test();
        for (int i = 0; i < 9; i++) begin
            a = 32'h100 + 4 * i;
            store_data(size_w, a, 32'h8000_0000 | $random(seed));   // Negative when signed
            run_op(mem_atomic, size_w, (i == 6 || i == 8) ? op_unsigned : op_signed,
                   amo_at(i), a, $random(seed) & 32'h7fff_ffff);
            load_data(size_w, op_unsigned, a);
        end
        end_test("AMO operations");

        begin_test();
        store_data(size_w, 32'h200, $random(seed));
        store_data(size_w, 32'h204, $random(seed));
        run_op(mem_atomic, size_w, op_signed, amo_lr, 32'h200, '0);
        run_op(mem_atomic, size_w, op_signed, amo_sc, 32'h200, $random(seed));
        load_data(size_w, op_unsigned, 32'h200);
        run_op(mem_atomic, size_w, op_signed, amo_sc, 32'h200, $random(seed));
        load_data(size_w, op_unsigned, 32'h200);
        run_op(mem_atomic, size_w, op_signed, amo_lr, 32'h200, '0);
        run_op(mem_atomic, size_w, op_signed, amo_sc, 32'h204, $random(seed));
        load_data(size_w, op_unsigned, 32'h204);
        load_data(size_w, op_unsigned, 32'h200);
        end_test("LR and SC");

        begin_test();
        store_data(size_w, 32'h10, $random(seed));
        load_data(size_w, op_unsigned, 32'h410);   // Word 260 aliases word 4
        load_data(size_b, op_signed, 32'h413);
        store_data(size_w, 32'h410, $random(seed));
        run_op(mem_atomic, size_w, op_signed, amo_add, 32'h410, $random(seed));
        load_data(size_w, op_unsigned, 32'h10);
        end_test("access faults");

        begin_test();
        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            run_op(mem_none, size_w, op_signed, amo_lr, (r % mem_words) * 4, r);
        end
        load_data(size_w, op_unsigned, 32'h100);
        load_data(size_h, op_signed, 32'h102);
        end_test("stall timing");

        repeat (2) @(posedge clk);
        $display("Finished %0d tests: %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/mem_stage_pkg.sv
hw/mem_stage_fsm.sv
hw/mem_data_format.sv
hw/dmem_latency_timer.sv
hw/dmem_array.sv
hw/mem_stage_top.sv
verif/mem_stage_checker.sv
verif/tb_mem_stage.sv
